/* project.f */
+incdir+bench
hw/hack_cpu_pkg.sv
hw/hack_isa_pkg.sv
hw/hack_alu.sv
hw/cpu_sequencer.sv
hw/program_counter.sv
hw/hack_registers.sv
hw/hack_cpu.sv
bench/hack_cpu_tb.sv

/* Makefile */
TOP = hack_cpu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/hack_ref_model.svh */
`ifndef HACK_REF_MODEL_SVH
`define HACK_REF_MODEL_SVH

//////////////////////////////////////////////////////////////
// instruction-level reference model and program generator
//////////////////////////////////////////////////////////////

logic [5:0] comp_codes [18] = '{
  6'b101010, 6'b111111, 6'b111010, 6'b001100, 6'b110000, 6'b001101,
  6'b110001, 6'b001111, 6'b110011, 6'b011111, 6'b110111, 6'b001110,
  6'b110010, 6'b000010, 6'b010011, 6'b000111, 6'b000000, 6'b010101
};

function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] v;
  v = s;
  v = v ^ (v << 13);
  v = v ^ (v >> 17);
  v = v ^ (v << 5);
  return v;
endfunction

function automatic logic [15:0] ram_fill(input int addr);
  return 16'(addr * 40503) ^ 16'h5a3c;  // every address bit matters
endfunction

// Hack mnemonics, y is A or M
function automatic logic [15:0] alu_ref(input logic [5:0] comp, input logic [15:0] d,
                                        input logic [15:0] y);
  case (comp)
    6'b101010: return 16'd0;
    6'b111111: return 16'd1;
    6'b111010: return 16'hffff;
    6'b001100: return d;
    6'b110000: return y;
    6'b001101: return ~d;
    6'b110001: return ~y;
    6'b001111: return 16'd0 - d;
    6'b110011: return 16'd0 - y;
    6'b011111: return d + 16'd1;
    6'b110111: return y + 16'd1;
    6'b001110: return d - 16'd1;
    6'b110010: return y - 16'd1;
    6'b000010: return d + y;
    6'b010011: return d - y;
    6'b000111: return y - d;
    6'b000000: return d & y;
    default:   return d | y;
  endcase
endfunction

function automatic logic jump_ref(input logic [2:0] cond, input logic [15:0] r);
  logic lt;
  logic eq;
  lt = r[15];
  eq = (r == 16'd0);
  case (cond)
    jmp_none: return 1'b0;
    jmp_jgt:  return !lt && !eq;
    jmp_jeq:  return eq;
    jmp_jge:  return !lt;
    jmp_jlt:  return lt;
    jmp_jne:  return !eq;
    jmp_jle:  return lt || eq;
    default:  return 1'b1;
  endcase
endfunction

// forward jumps only, so every run reaches the end of the program
task automatic gen_program();
  int i;
  int target;
  logic [31:0] r;
  i = 0;
  while (i < prog_len) begin
    rng_state = xorshift(rng_state);
    r = rng_state;
    target = i + 2 + int'(r[23:8] % 16'(prog_len - i - 2 + 1));
    if (i < prog_len - 2 && r[2:0] == 3'd0 && target < prog_len) begin
      rom[i]     = 16'(target);
      rom[i + 1] = {3'b111, r[24], comp_codes[r[31:27] % 18], r[28:26], r[7:5]};
      i = i + 2;
    end else if (r[4:3] == 2'd0) begin
      rom[i] = {1'b0, r[30:16]};
      i = i + 1;
    end else begin
      rom[i] = {3'b111, r[24], comp_codes[r[31:27] % 18], r[22:20], 3'b000};
      i = i + 1;
    end
  end
endtask

`endif

/* bench/hack_cpu_tb.sv */
`timescale 1ns/1ps

module hack_cpu_tb;

  import hack_cpu_pkg::*;
  import hack_isa_pkg::*;

  localparam int prog_len   = 200;
  localparam int ram_words  = 64;
  localparam int max_cycles = prog_len * 4 * 2 + 200;

  logic                  clk;
  logic                  reset;
  logic [word_width-1:0] instruction;
  logic                  mem_busy;
  logic [word_width-1:0] mem_rdata;
  logic [word_width-1:0] prog_counter;
  logic [word_width-1:0] mem_address;
  logic                  mem_write;
  logic [word_width-1:0] mem_wdata;

  logic [15:0] rom [256];
  logic [15:0] ram [ram_words];
  logic [15:0] model_ram [ram_words];
  logic [31:0] rng_state;
  int          cycle;
  int          mismatches;

  logic [15:0] m_pc;
  logic [15:0] m_a;
  logic [15:0] m_d;
  logic [15:0] m_result;
  logic [15:0] cur_inst;
  cpu_state_t  phase;
  logic [15:0] exp_pc;
  logic [15:0] exp_a;
  logic [15:0] exp_addr;
  logic [15:0] exp_data;
  logic        exp_store;
  logic        a_done;
  logic        c_done;
  logic        done;

  `include "hack_ref_model.svh"

  hack_cpu u_dut (
    .clk          (clk),
    .reset        (reset),
    .instruction  (instruction),
    .mem_busy     (mem_busy),
    .mem_rdata    (mem_rdata),
    .prog_counter (prog_counter),
    .mem_address  (mem_address),
    .mem_write    (mem_write),
    .mem_wdata    (mem_wdata)
  );

  assign instruction = rom[prog_counter[7:0]];
  assign mem_rdata   = ram[mem_address[5:0]];  // masked on the bench side only

  always @(posedge clk) begin
    if (!reset && mem_write && !mem_busy) begin
      ram[mem_address[5:0]] <= mem_wdata;
    end
  end

  task automatic report_value(input string name, input logic [15:0] got,
                              input logic [15:0] want);
    $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, want);
    $display("TEST FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic report_plain(input string what);
    $display("Error at %0d ns: %s", $time, what);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  //////////////////////////////////////////////////////////////
  // clock, reset, busy
  //////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    #1;
    if (cycle >= 10) begin
      rng_state = xorshift(rng_state);
      mem_busy <= (rng_state[9:8] == 2'd0);  // about one cycle in four
    end else begin
      mem_busy <= 1'b0;
    end
  end

  initial begin
    #(max_cycles * 10 + 100);
    report_plain("watchdog expired before the program retired");
  end

  //////////////////////////////////////////////////////////////
  // reference model, stepped on the edges the timing rules give
  //////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [15:0] y;
    logic        taken;
    a_done <= 1'b0;
    c_done <= 1'b0;
    if (reset) begin
      phase <= fetch;
    end else if (!mem_busy) begin
      case (phase)
        fetch: begin
          cur_inst = rom[m_pc[7:0]];
          phase <= decode;
        end
        decode: begin
          if (cur_inst[inst_class_bit] == a_inst) begin
            m_a = cur_inst;
            m_pc = m_pc + 16'd1;
            exp_a <= m_a;
            exp_pc <= m_pc;
            a_done <= 1'b1;
            done <= (m_pc >= prog_len);
            phase <= fetch;
          end else begin
            y = cur_inst[comp_select_bit] ? model_ram[m_a[5:0]] : m_a;
            m_result = alu_ref(cur_inst[comp_lsb +: comp_width], m_d, y);
            exp_addr <= m_a;
            exp_data <= m_result;
            exp_store <= cur_inst[dest_lsb + dest_m_bit];
            phase <= write_back;
          end
        end
        write_back: begin
          taken = jump_ref(cur_inst[jump_lsb +: jump_width], m_result);
          if (cur_inst[dest_lsb + dest_m_bit]) model_ram[m_a[5:0]] = m_result;
          m_pc = taken ? m_a : m_pc + 16'd1;  // old A is the target
          if (cur_inst[dest_lsb + dest_a_bit]) m_a = m_result;
          if (cur_inst[dest_lsb + dest_d_bit]) m_d = m_result;
          exp_pc <= m_pc;
          c_done <= 1'b1;
          done <= (m_pc >= prog_len);
          phase <= exp_store ? mem_wait : fetch;
        end
        default: phase <= fetch;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////

  reset_pc: assert property (@(posedge clk) $fell(reset) |-> prog_counter == 16'd0)
    else report_value("prog_counter", $sampled(prog_counter), 16'd0);
  reset_addr: assert property (@(posedge clk) $fell(reset) |-> mem_address == 16'd0)
    else report_value("mem_address", $sampled(mem_address), 16'd0);
  reset_write: assert property (@(posedge clk) $fell(reset) |-> !mem_write)
    else report_plain("mem_write is high right after reset");

  a_addr: assert property (@(posedge clk) disable iff (reset) a_done |-> mem_address == exp_a)
    else report_value("mem_address", $sampled(mem_address), $sampled(exp_a));
  pc_next: assert property (@(posedge clk) disable iff (reset)
    (a_done || c_done) |-> prog_counter == exp_pc)
    else report_value("prog_counter", $sampled(prog_counter), $sampled(exp_pc));

  store_strobe: assert property (@(posedge clk) disable iff (reset)
    mem_write == (phase == write_back && exp_store))
    else report_value("mem_write", 16'($sampled(mem_write)),
                      16'($sampled(phase == write_back && exp_store)));
  store_addr: assert property (@(posedge clk) disable iff (reset)
    mem_write |-> mem_address == exp_addr)
    else report_value("mem_address", $sampled(mem_address), $sampled(exp_addr));
  store_data: assert property (@(posedge clk) disable iff (reset)
    mem_write |-> mem_wdata == exp_data)
    else report_value("mem_wdata", $sampled(mem_wdata), $sampled(exp_data));
  store_once: assert property (@(posedge clk) disable iff (reset)
    (mem_write && !mem_busy) |=> !mem_write)
    else report_plain("mem_write stayed high after the store edge");

  busy_hold: assert property (@(posedge clk) disable iff (reset)
    mem_busy |=> $stable(prog_counter) && $stable(mem_address)
              && $stable(mem_wdata) && $stable(mem_write))
    else report_plain("outputs moved while mem_busy was high");

  initial begin
    reset = 1'b1;
    mem_busy = 1'b0;
    cycle = 0;
    done = 1'b0;
    m_pc = 16'd0;
    m_a = 16'd0;
    m_d = 16'd0;
    rng_state = 32'hf4157383;
    for (int i = 0; i < 256; i++) rom[i] = 16'd0;
    gen_program();
    for (int i = 0; i < ram_words; i++) begin
      ram[i] = ram_fill(i);
      model_ram[i] = ram_fill(i);
    end
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
    wait (done);
    repeat (3) @(posedge clk);
    mismatches = 0;
    for (int i = 0; i < ram_words && mismatches == 0; i++) begin
      if (ram[i] !== model_ram[i]) begin
        $display("Fail at %0d ns: ram[%0d] is %h, expected %h", $time, i, ram[i],
                 model_ram[i]);
        mismatches++;
      end
    end
    if (mismatches == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "final memory differs from the model");
    end
  end

endmodule

/* hw/hack_cpu.sv */
`timescale 1ns/1ps

module hack_cpu (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [hack_cpu_pkg::word_width-1:0] instruction,
  input  logic                                mem_busy,
  input  logic [hack_cpu_pkg::word_width-1:0] mem_rdata,
  output logic [hack_cpu_pkg::word_width-1:0] prog_counter,
  output logic [hack_cpu_pkg::word_width-1:0] mem_address,
  output logic                                mem_write,
  output logic [hack_cpu_pkg::word_width-1:0] mem_wdata
);

  import hack_cpu_pkg::*;
  import hack_isa_pkg::*;

  logic                  state_decode_c;
  logic                  a_load_inst;
  logic                  wb_enable;
  logic                  pc_inc;
  logic                  pc_jump;

  logic [word_width-1:0] a_value;
  logic [word_width-1:0] d_value;
  logic [word_width-1:0] alu_x;
  logic [word_width-1:0] alu_y;
  logic [word_width-1:0] alu_out;
  logic                  alu_zero;
  logic                  alu_neg;

  logic                  zx;
  logic                  nx;
  logic                  zy;
  logic                  ny;
  logic                  f;
  logic                  no;
  logic                  dest_m;
  logic [jump_width-1:0] jump_cond;

  cpu_sequencer u_sequencer (
    .clk            (clk),
    .reset          (reset),
    .mem_busy       (mem_busy),
    .instruction    (instruction),
    .jump_cond      (jump_cond),
    .alu_zero       (alu_zero),
    .alu_neg        (alu_neg),
    .dest_m         (dest_m),
    .state_decode_c (state_decode_c),
    .a_load_inst    (a_load_inst),
    .wb_enable      (wb_enable),
    .pc_inc         (pc_inc),
    .pc_jump        (pc_jump),
    .mem_write      (mem_write)
  );

  program_counter u_program_counter (
    .clk          (clk),
    .reset        (reset),
    .mem_busy     (mem_busy),
    .pc_inc       (pc_inc),
    .pc_jump      (pc_jump),
    .jump_target  (a_value),
    .prog_counter (prog_counter)
  );

  hack_registers u_registers (
    .clk            (clk),
    .reset          (reset),
    .mem_busy       (mem_busy),
    .instruction    (instruction),
    .mem_rdata      (mem_rdata),
    .alu_out        (alu_out),
    .state_decode_c (state_decode_c),
    .a_load_inst    (a_load_inst),
    .wb_enable      (wb_enable),
    .a_value        (a_value),
    .d_value        (d_value),
    .alu_x          (alu_x),
    .alu_y          (alu_y),
    .zx             (zx),
    .nx             (nx),
    .zy             (zy),
    .ny             (ny),
    .f              (f),
    .no             (no),
    .dest_m         (dest_m),
    .jump_cond      (jump_cond)
  );

  hack_alu u_alu (
    .x    (alu_x),
    .y    (alu_y),
    .zx   (zx),
    .nx   (nx),
    .zy   (zy),
    .ny   (ny),
    .f    (f),
    .no   (no),
    .out  (alu_out),
    .zero (alu_zero),
    .neg  (alu_neg)
  );

  assign mem_address = a_value;
  assign mem_wdata   = alu_out;

  // x operand is the D value seen at decode
  a_x_from_d: assert property (@(posedge clk) disable iff (reset)
    (state_decode_c && !mem_busy) |=> (alu_x == $past(d_value)));

  // a taken jump lands on the A value held during write-back
  a_jump_to_a: assert property (@(posedge clk) disable iff (reset)
    (pc_jump && !mem_busy) |=> (prog_counter == $past(a_value)));

endmodule

/* hw/hack_registers.sv */
`timescale 1ns/1ps

module hack_registers (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                mem_busy,
  input  logic [hack_cpu_pkg::word_width-1:0] instruction,
  input  logic [hack_cpu_pkg::word_width-1:0] mem_rdata,
  input  logic [hack_cpu_pkg::word_width-1:0] alu_out,
  input  logic                                state_decode_c,
  input  logic                                a_load_inst,
  input  logic                                wb_enable,
  output logic [hack_cpu_pkg::word_width-1:0] a_value,
  output logic [hack_cpu_pkg::word_width-1:0] d_value,
  output logic [hack_cpu_pkg::word_width-1:0] alu_x,
  output logic [hack_cpu_pkg::word_width-1:0] alu_y,
  output logic                                zx,
  output logic                                nx,
  output logic                                zy,
  output logic                                ny,
  output logic                                f,
  output logic                                no,
  output logic                                dest_m,
  output logic [hack_isa_pkg::jump_width-1:0] jump_cond
);

  import hack_isa_pkg::*;

  logic [dest_width-1:0] dest;

  //////////////////////////////////////////////////////////////
  // A and D
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      a_value <= '0;
      d_value <= '0;
    end else if (!mem_busy) begin
      if (a_load_inst) begin
        a_value <= instruction;
      end else if (wb_enable && dest[dest_a_bit]) begin
        a_value <= alu_out;  // same edge as the store, which sees the old A
      end
      if (wb_enable && dest[dest_d_bit]) begin
        d_value <= alu_out;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // C-instruction latches
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      {zx, nx, zy, ny, f, no} <= '0;
      dest                    <= '0;
      jump_cond               <= '0;
    end else if (!mem_busy && state_decode_c) begin
      {zx, nx, zy, ny, f, no} <= instruction[comp_lsb +: comp_width];
      dest                    <= instruction[dest_lsb +: dest_width];
      jump_cond               <= instruction[jump_lsb +: jump_width];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      alu_x <= '0;
      alu_y <= '0;
    end else if (!mem_busy && state_decode_c) begin
      alu_x <= d_value;
      alu_y <= instruction[comp_select_bit] ? mem_rdata : a_value;  // M or A
    end
  end

  assign dest_m = dest[dest_m_bit];

endmodule

/* hw/program_counter.sv */
`timescale 1ns/1ps

module program_counter (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                mem_busy,
  input  logic                                pc_inc,
  input  logic                                pc_jump,
  input  logic [hack_cpu_pkg::word_width-1:0] jump_target,
  output logic [hack_cpu_pkg::word_width-1:0] prog_counter
);

  import hack_cpu_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      prog_counter <= reset_address;
    end else if (!mem_busy) begin
      if (pc_jump) begin
        prog_counter <= jump_target;  // A from before write-back
      end else if (pc_inc) begin
        prog_counter <= prog_counter + word_width'(1);
      end
    end
  end

  // the sequencer picks one of the two per instruction
  a_inc_xor_jump: assert property (@(posedge clk) disable iff (reset)
    !(pc_inc && pc_jump));

endmodule

/* hw/cpu_sequencer.sv */
`timescale 1ns/1ps

module cpu_sequencer (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  mem_busy,
  input  logic [hack_cpu_pkg::word_width-1:0]   instruction,
  input  logic [hack_isa_pkg::jump_width-1:0]   jump_cond,
  input  logic                                  alu_zero,
  input  logic                                  alu_neg,
  input  logic                                  dest_m,
  output logic                                  state_decode_c,
  output logic                                  a_load_inst,
  output logic                                  wb_enable,
  output logic                                  pc_inc,
  output logic                                  pc_jump,
  output logic                                  mem_write
);

  import hack_cpu_pkg::*;
  import hack_isa_pkg::*;

  cpu_state_t  state;
  cpu_state_t  state_next;
  inst_class_t inst_class;
  logic        alu_pos;
  logic        taken;

  assign inst_class = inst_class_t'(instruction[inst_class_bit]);

  //////////////////////////////////////////////////////////////
  // jump decision, only place the condition is tested
  //////////////////////////////////////////////////////////////

  assign alu_pos = !(alu_neg || alu_zero);

  assign taken = (jump_cond[jump_lt_bit] && alu_neg)
              || (jump_cond[jump_eq_bit] && alu_zero)
              || (jump_cond[jump_gt_bit] && alu_pos);

  //////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      fetch:      state_next = decode;
      decode:     state_next = (inst_class == c_inst) ? write_back : fetch;
      write_back: state_next = dest_m ? mem_wait : fetch;
      mem_wait:   state_next = fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fetch;
    end else if (!mem_busy) begin  // frozen while memory is busy
      state <= state_next;
    end
  end

  //////////////////////////////////////////////////////////////
  // datapath strobes
  //////////////////////////////////////////////////////////////

  assign state_decode_c = (state == decode) && (inst_class == c_inst);
  assign a_load_inst    = (state == decode) && (inst_class == a_inst);
  assign wb_enable      = (state == write_back);

  assign pc_inc  = a_load_inst || (wb_enable && !taken);
  assign pc_jump = wb_enable && taken;

  assign mem_write = wb_enable && dest_m;  // held with state under busy

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(state) && (state inside {fetch, decode, write_back, mem_wait}));

  a_write_only_in_wb: assert property (@(posedge clk) disable iff (reset)
    mem_write |-> (state == write_back));

  // a busy cycle never lets the controller move
  a_busy_holds_state: assert property (@(posedge clk) disable iff (reset)
    mem_busy |=> $stable(state));

endmodule

/* hw/hack_alu.sv */
`timescale 1ns/1ps

module hack_alu (
  input  logic [hack_cpu_pkg::word_width-1:0] x,
  input  logic [hack_cpu_pkg::word_width-1:0] y,
  input  logic                                zx,
  input  logic                                nx,
  input  logic                                zy,
  input  logic                                ny,
  input  logic                                f,
  input  logic                                no,
  output logic [hack_cpu_pkg::word_width-1:0] out,
  output logic                                zero,
  output logic                                neg
);

  import hack_cpu_pkg::*;

  logic [word_width-1:0] x_zeroed;
  logic [word_width-1:0] x_final;
  logic [word_width-1:0] y_zeroed;
  logic [word_width-1:0] y_final;
  logic [word_width-1:0] sum;
  logic [word_width-1:0] conj;
  logic [word_width-1:0] result;

  //////////////////////////////////////////////////////////////
  // operand conditioning
  //////////////////////////////////////////////////////////////

  assign x_zeroed = zx ? '0 : x;
  assign x_final  = nx ? ~x_zeroed : x_zeroed;

  assign y_zeroed = zy ? '0 : y;
  assign y_final  = ny ? ~y_zeroed : y_zeroed;

  //////////////////////////////////////////////////////////////
  // function and output stage
  //////////////////////////////////////////////////////////////

  assign sum  = x_final + y_final;  // wraps at 16 bits
  assign conj = x_final & y_final;

  assign result = f ? sum : conj;
  assign out    = no ? ~result : result;

  assign zero = (out == '0);
  assign neg  = out[word_width-1];  // two's complement sign

endmodule

/* hw/hack_isa_pkg.sv */
package hack_isa_pkg;

  //////////////////////////////////////////////////////////////
  // instruction layout
  //////////////////////////////////////////////////////////////

  localparam int inst_class_bit  = 15;  // 0 = A-instruction, 1 = C-instruction
  localparam int comp_select_bit = 12;  // y operand is M when set, A when clear
  localparam int comp_lsb        = 6;   // zx nx zy ny f no, zx at the top
  localparam int dest_lsb        = 3;
  localparam int jump_lsb        = 0;

  localparam int comp_width = 6;
  localparam int dest_width = 3;
  localparam int jump_width = 3;

  typedef enum logic {
    a_inst = 1'b0,
    c_inst = 1'b1
  } inst_class_t;

  //////////////////////////////////////////////////////////////
  // dest field, bit positions inside the 3-bit field
  //////////////////////////////////////////////////////////////

  localparam int dest_a_bit = 2;  // d1
  localparam int dest_d_bit = 1;  // d2
  localparam int dest_m_bit = 0;  // d3, store to memory at A

  //////////////////////////////////////////////////////////////
  // jump field
  //////////////////////////////////////////////////////////////

  localparam int jump_lt_bit = 2;  // j1, result negative
  localparam int jump_eq_bit = 1;  // j2, result zero
  localparam int jump_gt_bit = 0;  // j3, result positive

  // the eight mnemonics
  localparam logic [jump_width-1:0] jmp_none = 3'b000;
  localparam logic [jump_width-1:0] jmp_jgt  = 3'b001;
  localparam logic [jump_width-1:0] jmp_jeq  = 3'b010;
  localparam logic [jump_width-1:0] jmp_jge  = 3'b011;
  localparam logic [jump_width-1:0] jmp_jlt  = 3'b100;
  localparam logic [jump_width-1:0] jmp_jne  = 3'b101;
  localparam logic [jump_width-1:0] jmp_jle  = 3'b110;
  localparam logic [jump_width-1:0] jmp_jmp  = 3'b111;

endpackage

/* hw/hack_cpu_pkg.sv */
package hack_cpu_pkg;

  localparam int word_width = 16;  // data, address and instruction

  localparam logic [word_width-1:0] reset_address = '0;

  //////////////////////////////////////////////////////////////
  // controller
  //////////////////////////////////////////////////////////////

  // fetch      instruction word settles at prog_counter
  // decode     A loads, or C operands and controls latch
  // write_back dest registers, store strobe, pc update
  // mem_wait   extra cycle after a store
  typedef enum logic [1:0] {
    fetch      = 2'd0,
    decode     = 2'd1,
    write_back = 2'd2,
    mem_wait   = 2'd3
  } cpu_state_t;

endpackage
